// ==== verif/umode_patterns.txt ====
# mode insn trap intr misa mstatus_r mstatus_w mstatus_wmask mscratch_wmask gap exp_viol
# all hex, trap is {trap, exception, cause[5:0]}, gap is idle cycles after the retirement
3 00000013 00 0 40101100 00001800 00000000 00000000 00000000 0 0000
3 300020F3 00 0 40101100 00001800 00000000 00000000 00000000 1 0000
0 00000013 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
0 C00020F3 00 0 40101100 00000000 00000000 00000000 00000000 2 0000
0 00000073 C8 0 40101100 00000000 00000000 00000000 00000000 3 0000
3 00000013 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
3 00000013 00 0 40001100 00001800 00000000 00000000 00000000 0 0001
2 00000013 00 0 40101100 00001800 00000000 00000000 00000000 0 0002
3 00000013 00 0 40101100 00001900 00000000 00000000 00000000 1 0008
3 00000013 00 0 40101100 00003800 00000000 00000000 00000000 0 0010
0 00000013 00 0 40101100 00000000 00000000 00000000 FFFFFFFF 0 0020
3 30009073 00 0 40101100 00000000 00001000 00001800 00000000 0 0004
0 00000073 00 0 40101100 00000000 00000000 00000000 00000000 0 0800
3 8C000073 00 0 40101100 00001800 00000000 00000000 00000000 0 0200
3 8C000073 C2 0 40101100 00001800 00000000 00000000 00000000 1 0000
3 00000013 00 0 40101100 00001800 00000000 00000000 00000000 0 0000
0 10500073 00 0 40101100 00200000 00000000 00000000 00000000 0 0100
0 10500073 C2 0 40101100 00200000 00000000 00000000 00000000 0 0000
3 00000013 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
0 10500073 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
0 300020F3 00 0 40101100 00000000 00000000 00000000 00000000 0 1000
0 300020F3 C2 0 40101100 00000000 00000000 00000000 00000000 1 0000
3 00000013 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
3 30200073 00 0 40101100 00001800 00000000 00000000 00000000 0 0040
3 30200073 00 0 40101100 00020000 00000000 00000000 00000000 0 0080
3 30200073 00 0 40101100 00000000 00000000 00000000 00000000 0 0000
3 00200073 00 0 40101100 00001800 00000000 00000000 00000000 0 0400
0 00000013 00 1 40101100 00000000 00000000 00000000 00000000 0 2000
0 00000073 C8 0 40101100 00000000 00000000 00000000 00000000 2 0000
0 00000013 00 0 40101100 00000000 00000000 00000000 00000000 0 4000
0 00000073 C8 0 40101100 00000000 00000000 00000000 00000000 1 0000
3 00000013 00 0 40101100 00001800 00000000 00000000 00000000 0 8000
3 00000013 00 0 40101100 00001800 00000000 00000000 00000000 0 0000

// ==== vlog.f ====
src/umode_pkg.sv
src/insn_decoder.sv
src/status_field_checker.sv
src/insn_rule_checker.sv
src/trap_sequence_tracker.sv
src/violation_reporter.sv
src/umode_checker_top.sv
verif/check_monitor.sv
verif/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --top-module tb_top -f vlog.f &&
  out=$(./obj_dir/Vtb_top) &&
  echo "$out" &&
  echo "$out" | grep -q "test passed" ||
  { echo "simulation failed"; exit 1; }

// ==== verif/tb_top.sv ====
/*
 * Testbench for the user-mode privilege checker
 *
 * Reads retirements and their expected flags from the pattern file,
 * drives them into the DUT with the listed idle gaps and closes with a
 * summary once every retirement has been checked.
 */
`timescale 1ns/1ns

module tb_top;

  import umode_pkg::*;

  localparam int    CNT_W        = 16;
  localparam string PATTERN_FILE = "verif/umode_patterns.txt";

  logic             clk_i = 1'b0;
  logic             rst_ni;
  retire_t          retire;
  logic             viol_valid;
  viol_t            viol;
  logic [CNT_W-1:0] viol_count;

  logic  exp_valid;
  viol_t exp_viol;
  logic  count_check;
  int    checked;
  int    err_count;

  retire_t rec_q[$];
  viol_t   exp_q[$];
  int      gap_q[$];
  bit      load_ok     = 1'b0;
  int      cycle_cnt   = 0;
  int      cycle_limit = 100;

  always #10 clk_i = ~clk_i;

  umode_checker_top #(
    .CNT_W (CNT_W)
  ) DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .retire     (retire),
    .viol_valid (viol_valid),
    .viol       (viol),
    .viol_count (viol_count)
  );

  check_monitor #(
    .CNT_W (CNT_W)
  ) u_monitor (
    .clk_i       (clk_i),
    .exp_valid   (exp_valid),
    .exp_viol    (exp_viol),
    .viol_valid  (viol_valid),
    .viol        (viol),
    .viol_count  (viol_count),
    .count_check (count_check),
    .checked     (checked),
    .err_count   (err_count)
  );

  // Fills the record queues and sizes the timeout from the gaps
  task automatic load_patterns();
    int          fd;
    int          n;
    int          total;
    bit          bad;
    string       line;
    logic [31:0] mode, insn, trap, intr, misa, mst_r, mst_w, mst_m, scr_m, gap, exp;
    retire_t     rec;
    total = 0;
    bad   = 1'b0;
    fd    = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open pattern file %s", PATTERN_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", mode, insn, trap,
                      intr, misa, mst_r, mst_w, mst_m, scr_m, gap, exp);
          if (n != 11) begin
            $display("malformed pattern line: %s", line);
            bad = 1'b1;
          end else begin
            rec                = '0;
            rec.valid          = 1'b1;
            rec.mode           = mode[1:0];
            rec.insn           = insn;
            rec.trap           = trap[7:0];
            rec.intr           = intr[0];
            rec.misa_rdata     = misa;
            rec.mstatus_rdata  = mst_r;
            rec.mstatus_wdata  = mst_w;
            rec.mstatus_wmask  = mst_m;
            rec.mscratch_wmask = scr_m;
            rec_q.push_back(rec);
            gap_q.push_back(int'(gap));
            exp_q.push_back(exp[15:0]);
            total += 1 + int'(gap);
          end
        end
      end
      $fclose(fd);
      if (rec_q.size() == 0) begin
        $display("pattern file holds no retirements");
      end
      load_ok     = !bad && (rec_q.size() > 0);
      cycle_limit = 4 * total + 100;
    end
  endtask

  task automatic run_patterns();
    for (int i = 0; i < rec_q.size(); i++) begin
      @(posedge clk_i);
      retire    <= rec_q[i];
      exp_valid <= 1'b1;
      exp_viol  <= exp_q[i];
      for (int g = 0; g < gap_q[i]; g++) begin
        @(posedge clk_i);
        retire    <= '0;
        exp_valid <= 1'b0;
      end
    end
    @(posedge clk_i);
    retire    <= '0;
    exp_valid <= 1'b0;
  endtask

  initial begin
    rst_ni      <= 1'b0;
    retire      <= '0;
    exp_valid   <= 1'b0;
    exp_viol    <= '0;
    count_check <= 1'b0;
    load_patterns();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    if (load_ok) begin
      run_patterns();
      // Each retirement answers with exactly one pulse
      while (checked < rec_q.size()) @(posedge clk_i);
      @(posedge clk_i);
      count_check <= 1'b1;
      @(posedge clk_i);
      count_check <= 1'b0;
      @(posedge clk_i);
    end
    $display("summary: %0d of %0d retirements checked, %0d errors",
             checked, rec_q.size(), err_count);
    if (load_ok && err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles with DUT results still outstanding", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

endmodule

// ==== verif/check_monitor.sv ====
/*
 * Result monitor
 *
 * Queues the expected flags of each retirement, checks that viol_valid
 * pulses one cycle after each retirement, compares the registered DUT
 * flags on every pulse and checks the final violation count against the
 * number of violating retirements.
 */
`timescale 1ns/1ns

module check_monitor #(
  parameter int CNT_W = 16
) (
  input  logic             clk_i,
  input  logic             exp_valid,
  input  umode_pkg::viol_t exp_viol,
  input  logic             viol_valid,
  input  umode_pkg::viol_t viol,
  input  logic [CNT_W-1:0] viol_count,
  input  logic             count_check,
  output int               checked,
  output int               err_count
);

  import umode_pkg::*;

  viol_t            exp_q[$];
  viol_t            exp_head;
  logic [CNT_W-1:0] exp_count = '0;
  logic             exp_pulse = 1'b0;
  int               n_checked = 0;
  int               n_err     = 0;

  assign checked   = n_checked;
  assign err_count = n_err;

  always @(posedge clk_i) begin
    // viol_valid rises one cycle after each retirement and at no other time
    if ((viol_valid === 1'b1) != exp_pulse) begin
      $display("ERR viol_valid exp 0x%0h got 0x%0h", exp_pulse, viol_valid);
      n_err <= n_err + 1;
    end
    exp_pulse <= exp_valid;

    // One pulse per retirement, in retirement order
    if (viol_valid) begin
      if (exp_q.size() == 0) begin
        $display("viol_valid pulse with no retirement outstanding");
        n_err <= n_err + 1;
      end else begin
        exp_head = exp_q.pop_front();
        if (viol !== exp_head) begin
          $display("ERR viol test %0d exp 0x%04h got 0x%04h",
                   n_checked + 1, exp_head, viol);
          n_err <= n_err + 1;
        end else begin
          $display("test %0d ok, viol 0x%04h", n_checked + 1, viol);
        end
        n_checked <= n_checked + 1;
      end
    end

    if (exp_valid) begin
      exp_q.push_back(exp_viol);
      if (exp_viol != '0) begin
        exp_count <= exp_count + 1'b1;
      end
    end

    if (count_check) begin
      if (viol_count !== exp_count) begin
        $display("ERR viol_count exp 0x%0h got 0x%0h", exp_count, viol_count);
        n_err <= n_err + 1;
      end else begin
        $display("viol_count ok, 0x%0h violating retirements", viol_count);
      end
    end
  end

endmodule

// ==== src/umode_checker_top.sv ====
/*
 * User-mode privilege checker top level
 *
 * Decodes each retirement, runs the field, outcome and trap sequence
 * checks and reports registered flags with a violation count.
 */
`timescale 1ns/1ns

module umode_checker_top #(
  parameter int CNT_W = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  umode_pkg::retire_t retire,
  output logic               viol_valid,
  output umode_pkg::viol_t   viol,
  output logic [CNT_W-1:0]   viol_count
);

  import umode_pkg::*;

  insn_class_t insn_class;
  viol_t       field_viol;
  viol_t       rule_viol;
  viol_t       seq_viol;

  insn_decoder u_decoder (
    .retire     (retire),
    .insn_class (insn_class)
  );

  status_field_checker u_field_chk (
    .retire     (retire),
    .insn_class (insn_class),
    .viol       (field_viol)
  );

  insn_rule_checker u_rule_chk (
    .retire     (retire),
    .insn_class (insn_class),
    .viol       (rule_viol)
  );

  trap_sequence_tracker u_seq_trk (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .retire (retire),
    .viol   (seq_viol)
  );

  violation_reporter #(
    .CNT_W (CNT_W)
  ) u_reporter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .retire_valid (retire.valid),
    .field_viol   (field_viol),
    .rule_viol    (rule_viol),
    .seq_viol     (seq_viol),
    .viol_valid   (viol_valid),
    .viol         (viol),
    .viol_count   (viol_count)
  );

endmodule

// ==== src/violation_reporter.sv ====
/*
 * Violation reporter
 *
 * Merges the partial flag vectors, registers them with a valid pulse one
 * cycle after each retirement and counts violating retirements in a
 * saturating counter.
 */
`timescale 1ns/1ns

module violation_reporter #(
  parameter int CNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  retire_valid,
  input  umode_pkg::viol_t      field_viol,
  input  umode_pkg::viol_t      rule_viol,
  input  umode_pkg::viol_t      seq_viol,
  output logic                  viol_valid,
  output umode_pkg::viol_t      viol,
  output logic [CNT_W-1:0]      viol_count
);

  import umode_pkg::*;

  viol_t merged;
  logic  any_viol;

  assign merged   = field_viol | rule_viol | seq_viol;
  assign any_viol = retire_valid && (merged != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      viol_valid <= 1'b0;
      viol       <= '0;
      viol_count <= '0;
    end else begin
      viol_valid <= retire_valid;
      viol       <= retire_valid ? merged : '0;
      // Hold at the top value
      if (any_viol && (viol_count != {CNT_W{1'b1}})) begin
        viol_count <= viol_count + 1'b1;
      end
    end
  end

  a_valid_follows_retire: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> (viol_valid == $past(retire_valid))
  ) else $error("viol_valid does not follow retire_valid");

endmodule

// ==== src/trap_sequence_tracker.sv ====
/*
 * Trap sequence tracker
 *
 * Saves the mode of a trapping retirement. The next retirement, after
 * any number of idle cycles, must run in M with MPP holding the saved
 * mode.
 */
`timescale 1ns/1ns

module trap_sequence_tracker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  umode_pkg::retire_t retire,
  output umode_pkg::viol_t   viol
);

  import umode_pkg::*;

  logic       pending;
  priv_mode_t saved_mode;
  priv_mode_t read_mpp;

  assign read_mpp = retire.mstatus_rdata[MPP_POS +: 2];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending <= 1'b0;
    end else if (retire.valid) begin
      pending <= retire.trap.trap;
    end
  end

  // Mode of the trapping retirement
  always_ff @(posedge clk_i) begin
    if (retire.valid && retire.trap.trap) begin
      saved_mode <= retire.mode;
    end
  end

  always_comb begin
    viol = '0;
    if (retire.valid && pending) begin
      viol.trap_not_mmode = (retire.mode != MODE_M);
      viol.trap_mpp_wrong = (read_mpp != saved_mode);
    end
  end

  a_no_pending_after_reset: assert property (
    @(posedge clk_i) !rst_ni |=> !pending
  ) else $error("trap pending right after reset");

endmodule

// ==== src/insn_rule_checker.sv ====
/*
 * Instruction outcome checker
 *
 * Checks how privileged instructions retire. In U mode WFI follows
 * mstatus.TW, ECALL traps with the U-mode cause and higher CSRs are
 * illegal. Custom SYSTEM opcodes and URET are illegal in any mode.
 */
`timescale 1ns/1ns

module insn_rule_checker (
  input  umode_pkg::retire_t     retire,
  input  umode_pkg::insn_class_t insn_class,
  output umode_pkg::viol_t       viol
);

  import umode_pkg::*;

  logic in_umode;
  logic ecall_trap_ok;
  logic tw;

  assign in_umode      = retire.valid && (retire.mode == MODE_U);
  assign tw            = retire.mstatus_rdata[TW_POS];
  assign ecall_trap_ok = retire.trap.trap && retire.trap.exception &&
                         (retire.trap.cause == CAUSE_ECALL_U);

  always_comb begin
    viol = '0;

    // WFI traps exactly when TW is set
    viol.wfi_tw_wrong   = in_umode && insn_class.is_wfi && (insn_class.illegal != tw);
    viol.ecall_wrong    = in_umode && insn_class.is_ecall && !ecall_trap_ok;
    viol.csr_priv_legal = in_umode && insn_class.csr_above_u && !insn_class.illegal;

    viol.custom_legal = insn_class.is_custom && !insn_class.illegal;
    viol.uret_legal   = insn_class.is_uret && !insn_class.illegal;

    // Interrupts are always taken into M
    viol.intr_not_mmode = retire.valid && retire.intr && (retire.mode != MODE_M);
  end

  // Idle cycles must not leak flags through the decoder classes
  always_comb begin
    a_idle_no_flags: assert final (retire.valid || (viol == '0))
      else $error("rule flags set without a retirement");
  end

endmodule

// ==== src/status_field_checker.sv ====
/*
 * Status field checker
 *
 * Checks misa, mstatus and mscratch against the rules of an M/U-only
 * hart. The mstatus post-state merges written and read bits, and MRET
 * results are checked against it.
 */
`timescale 1ns/1ns

module status_field_checker (
  input  umode_pkg::retire_t     retire,
  input  umode_pkg::insn_class_t insn_class,
  output umode_pkg::viol_t       viol
);

  import umode_pkg::*;

  logic [31:0] post_mstatus;
  priv_mode_t  post_mpp;
  priv_mode_t  read_mpp;
  logic [31:0] misa;

  assign post_mstatus = (retire.mstatus_wdata & retire.mstatus_wmask) |
                        (retire.mstatus_rdata & ~retire.mstatus_wmask);
  assign post_mpp     = post_mstatus[MPP_POS +: 2];
  assign read_mpp     = retire.mstatus_rdata[MPP_POS +: 2];
  assign misa         = retire.misa_rdata;

  always_comb begin
    viol = '0;
    if (retire.valid) begin
      // U present, S and N absent
      viol.misa_bad = !misa[MISA_U_POS] || misa[MISA_S_POS] || misa[MISA_N_POS];

      viol.mode_bad = (retire.mode != MODE_U) && (retire.mode != MODE_M);
      viol.spp_bad  = retire.mstatus_rdata[SPP_POS];

      viol.ext_bits_bad = (retire.mstatus_rdata[XS_POS +: 2] != 2'b00) ||
                          (retire.mstatus_rdata[FS_POS +: 2] != 2'b00) ||
                          retire.mstatus_rdata[SD_POS];

      viol.mscratch_write = (retire.mode == MODE_U) && (retire.mscratch_wmask != '0);

      viol.mpp_bad = (post_mpp != MODE_U) && (post_mpp != MODE_M);

      // MRET drops MPP to the lowest mode
      viol.mret_mpp_not_u = insn_class.is_mret && (post_mpp != MODE_U);

      // Returning below M must clear MPRV
      viol.mret_mprv_set = insn_class.is_mret && (read_mpp != MODE_M) &&
                           post_mstatus[MPRV_POS];
    end
  end

endmodule

// ==== src/insn_decoder.sv ====
/*
 * Instruction decoder
 *
 * Classifies each retired instruction as MRET, WFI, URET, ECALL, custom
 * SYSTEM or CSR access, and flags an illegal-instruction trap outcome.
 * All classes are zero when no retirement is present.
 */
`timescale 1ns/1ns

module insn_decoder (
  input  umode_pkg::retire_t     retire,
  output umode_pkg::insn_class_t insn_class
);

  import umode_pkg::*;

  logic       is_system;
  logic [2:0] funct3;
  logic       custom_hit;

  assign is_system = (retire.insn.csr.opcode == SYSTEM_OPCODE);
  assign funct3    = retire.insn.csr.funct3;

  assign custom_hit = ((retire.insn.priv & CUSTOM_MASK) == CUSTOM0_MATCH) ||
                      ((retire.insn.priv & CUSTOM_MASK) == CUSTOM1_MATCH);

  always_comb begin
    insn_class = '0;
    if (retire.valid) begin
      insn_class.is_mret   = (retire.insn.priv == MRET_INSN);
      insn_class.is_wfi    = (retire.insn.priv == WFI_INSN);
      insn_class.is_uret   = (retire.insn.priv == URET_INSN);
      insn_class.is_ecall  = (retire.insn.priv == ECALL_INSN);
      insn_class.is_custom = custom_hit;

      // funct3 of 0 is the privileged group and 4 is reserved
      insn_class.is_csr = is_system && (funct3 != 3'd0) && (funct3 != 3'd4);

      // Address bits 9:8 give the lowest mode allowed to access the CSR
      insn_class.csr_above_u = insn_class.is_csr &&
                               (retire.insn.csr.addr[9:8] != MODE_U);

      insn_class.illegal = retire.trap.trap && retire.trap.exception &&
                           (retire.trap.cause == CAUSE_ILLEGAL);
    end
  end

endmodule

// ==== src/umode_pkg.sv ====
/*
 * User-mode privilege checker package
 *
 * Types for one retirement record, its trap outcome, the two decodings
 * of the instruction word, the instruction classes and the violation
 * flags, plus the misa and mstatus field positions and the privileged
 * SYSTEM encodings that the checkers compare against.
 */
package umode_pkg;

  // Privilege mode as reported at retirement
  typedef logic [1:0] priv_mode_t;

  localparam priv_mode_t MODE_U = 2'b00;
  localparam priv_mode_t MODE_M = 2'b11;

  // misa extension bits
  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // mstatus field positions
  localparam int MPP_POS  = 11;
  localparam int SPP_POS  = 8;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;
  localparam int XS_POS   = 15;
  localparam int FS_POS   = 13;
  localparam int SD_POS   = 31;

  localparam logic [6:0]  SYSTEM_OPCODE = 7'b1110011;

  localparam logic [31:0] MRET_INSN     = 32'h3020_0073;
  localparam logic [31:0] WFI_INSN      = 32'h1050_0073;
  localparam logic [31:0] URET_INSN     = 32'h0020_0073;
  localparam logic [31:0] ECALL_INSN    = 32'h0000_0073;

  // Custom SYSTEM opcodes match on funct6, funct3 and opcode only
  localparam logic [31:0] CUSTOM0_MATCH = 32'h8C00_0073;
  localparam logic [31:0] CUSTOM1_MATCH = 32'hCC00_0073;
  localparam logic [31:0] CUSTOM_MASK   = 32'hFC00_707F;

  localparam logic [5:0]  CAUSE_ILLEGAL = 6'd2;
  localparam logic [5:0]  CAUSE_ECALL_U = 6'd8;

  typedef struct packed {
    logic       trap;
    logic       exception;
    logic [5:0] cause;
  } trap_t;

  typedef struct packed {
    logic [11:0] addr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_insn_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } priv_insn_t;

  // Same word, seen as a CSR access or as a privileged SYSTEM instruction
  typedef union packed {
    csr_insn_t  csr;
    priv_insn_t priv;
  } insn_u;

  typedef struct packed {
    logic        valid;
    priv_mode_t  mode;
    insn_u       insn;
    trap_t       trap;
    logic        intr;
    logic [31:0] misa_rdata;
    logic [31:0] mstatus_rdata;
    logic [31:0] mstatus_wdata;
    logic [31:0] mstatus_wmask;
    logic [31:0] mscratch_wmask;
  } retire_t;

  typedef struct packed {
    logic is_mret;
    logic is_wfi;
    logic is_custom;
    logic is_uret;
    logic is_ecall;
    logic is_csr;
    logic csr_above_u;
    logic illegal;
  } insn_class_t;

  // Declared from bit 15 down to bit 0
  typedef struct packed {
    logic trap_mpp_wrong;
    logic trap_not_mmode;
    logic intr_not_mmode;
    logic csr_priv_legal;
    logic ecall_wrong;
    logic uret_legal;
    logic custom_legal;
    logic wfi_tw_wrong;
    logic mret_mprv_set;
    logic mret_mpp_not_u;
    logic mscratch_write;
    logic ext_bits_bad;
    logic spp_bad;
    logic mpp_bad;
    logic mode_bad;
    logic misa_bad;
  } viol_t;

endpackage
